/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_motor_bus
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bus_checker.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module bus_checker (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cyc,
	input  logic                                stb,
	input  logic                                we,
	input  logic [motor_bus_pkg::ADR_WIDTH-1:0] adr,
	input  logic [31:0]                         dat_w,
	input  logic [31:0]                         dat_r,
	input  logic                                ack,
	input  logic                                tx_o,
	input  logic                                tx_enable,
	input  logic                                exp_valid,
	input  motor_bus_pkg::motor_idx_t           exp_idx,
	input  logic [1:0]                          exp_kind,
	input  motor_bus_pkg::motor_status_t        exp_status,
	output int                                  checks,
	output int                                  errors
);
	import motor_bus_pkg::*;

	localparam int BIT = `BIT_CYCLES;

	logic [7:0]         bytes_q [$];
	logic signed [31:0] sp_m [`NUM_MOTORS];
	logic [7:0]         id_m [`NUM_MOTORS];
	motor_status_t      st_m [`NUM_MOTORS];
	poll_result_e       res_m [`NUM_MOTORS];
	motor_idx_t         next_idx, cmd_idx, midx;
	logic               pend_cmd, rx_busy, en_prev;
	logic [7:0]         sh;
	int                 ph, nframe;
	int                 wb_n; // cycles of the current bus access so far

	initial begin
		checks = 0;
		errors = 0;
		nframe = 0;
	end

	function automatic logic [15:0] crc_range(input int first, input int last);
		logic [15:0] c;
		c = 16'hFFFF;
		for (int k = first; k <= last; k++)
			for (int i = 7; i >= 0; i--)
				c = (c[15] ^ bytes_q[k][i]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		return c;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end else
			$display("ok   %s = %h", name, act);
	endtask

	task automatic check_frame;
		int          n;
		logic [31:0] hdr;
		logic [7:0]  id;
		string       tag;
		nframe++;
		if (pend_cmd) begin
			n = `CMD_FRAME_LEN;
			hdr = `CMD_HEADER;
			id = id_m[cmd_idx];
			tag = $sformatf("frame%0d cmd m%0d", nframe, cmd_idx);
		end else begin
			n = `REQ_FRAME_LEN;
			hdr = `REQ_HEADER;
			id = id_m[next_idx];
			tag = $sformatf("frame%0d req m%0d", nframe, next_idx);
		end
		if (bytes_q.size() != n) begin
			checks++;
			errors++;
			$display("%s has %0d bytes where %0d were due", tag, bytes_q.size(), n);
		end else begin
			check({tag, " header"}, hdr, {bytes_q[0], bytes_q[1], bytes_q[2], bytes_q[3]});
			check({tag, " id"}, {24'h0, id}, {24'h0, bytes_q[4]});
			if (pend_cmd)
				check({tag, " setpoint"}, sp_m[cmd_idx],
					{bytes_q[5], bytes_q[6], bytes_q[7], bytes_q[8]});
			check({tag, " crc"}, {16'h0, crc_range(4, n - 3)},
				{16'h0, bytes_q[n - 2], bytes_q[n - 1]});
		end
		if (pend_cmd)
			pend_cmd = 1'b0;
		else
			next_idx = (next_idx == motor_idx_t'(`NUM_MOTORS - 1)) ? '0 : next_idx + 1'b1;
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int m = 0; m < `NUM_MOTORS; m++) begin
				sp_m[m] = '0;
				id_m[m] = '0;
				res_m[m] = RES_NEVER;
			end
			next_idx = '0;
			pend_cmd = 1'b0;
			rx_busy = 1'b0;
			en_prev = 1'b0;
			wb_n = 0;
			bytes_q.delete();
		end else begin
			// ack belongs in the second cycle of an access and nowhere else
			if (cyc && stb)
				wb_n++;
			else
				wb_n = 0;
			if (ack !== (wb_n == 2)) begin
				checks++;
				errors++;
				$display("ack is %b in cycle %0d of a bus access at address %h",
					ack, wb_n, adr);
			end
			if (cyc && stb && ack) begin
				midx = adr[ADR_WIDTH-1:3];
				if (we) begin
					if (adr[2:0] == 3'd0)
						sp_m[midx] = dat_w;
					else if (adr[2:0] == 3'd1)
						id_m[midx] = dat_w[7:0];
				end else begin
					case (adr[2:0])
						3'd0: check($sformatf("m%0d setpoint", midx), sp_m[midx], dat_r);
						3'd1: check($sformatf("m%0d id", midx), {24'h0, id_m[midx]}, dat_r);
						3'd2: check($sformatf("m%0d echo", midx), st_m[midx].setpoint, dat_r);
						3'd3: check($sformatf("m%0d position", midx), st_m[midx].position, dat_r);
						3'd4: check($sformatf("m%0d velocity", midx), st_m[midx].velocity, dat_r);
						3'd5: check($sformatf("m%0d duty", midx), st_m[midx].duty, dat_r);
						default: check($sformatf("m%0d result", midx), 32'(res_m[midx]), dat_r);
					endcase
				end
			end
			if (exp_valid) begin
				case (exp_kind)
					2'd0: begin
						st_m[exp_idx] = exp_status;
						res_m[exp_idx] = RES_OK;
						if (exp_status.setpoint != sp_m[exp_idx]) begin
							pend_cmd = 1'b1;
							cmd_idx = exp_idx;
						end
					end
					2'd1: res_m[exp_idx] = RES_BAD_CRC;
					2'd2: res_m[exp_idx] = RES_WRONG_ID;
					default: res_m[exp_idx] = RES_TIMEOUT;
				endcase
			end
			// own uart decoder on tx_o
			if (!rx_busy) begin
				if (tx_enable && !tx_o) begin
					rx_busy = 1'b1;
					ph = 0;
				end
			end else begin
				ph++;
				if (ph % BIT == BIT / 2 && ph / BIT >= 1 && ph / BIT <= 8)
					sh = {tx_o, sh[7:1]};
				if (ph == 9 * BIT + BIT / 2) begin
					rx_busy = 1'b0;
					bytes_q.push_back(sh);
				end
			end
			if (en_prev && !tx_enable) begin
				check_frame();
				bytes_q.delete();
			end
			en_prev = tx_enable;
		end
	end
endmodule

/* bus_poller.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module bus_poller (
	input  logic                        clk,
	input  logic                        reset,
	input  motor_bus_pkg::motor_cfg_t   cfg,
	output motor_bus_pkg::motor_idx_t   sel,
	output motor_bus_pkg::frame_req_t   req,
	output logic                        send,
	input  logic                        sender_busy,
	output logic                        arm,
	output logic [7:0]                  expect_id,
	output logic                        abort,
	input  logic                        rx_done,
	input  motor_bus_pkg::poll_result_e rx_result,
	input  logic signed [31:0]          rx_setpoint,
	output logic                        timeout_mark
);
	import motor_bus_pkg::*;

	typedef enum logic [2:0] {ST_GAP, ST_REQUEST, ST_AWAIT, ST_COMMAND, ST_NEXT} poll_state_e;

	localparam int CW = $clog2(`RESP_TIMEOUT_CYCLES + `POLL_GAP_CYCLES);

	poll_state_e   state;
	logic [CW-1:0] cnt;
	logic          issued;
	logic          expired;

	assign expired = (state == ST_AWAIT) && !rx_done && !sender_busy
		&& (cnt == CW'(`RESP_TIMEOUT_CYCLES - 1));
	assign send = !sender_busy && (state == ST_REQUEST || (state == ST_COMMAND && !issued));
	assign arm = send && (state == ST_REQUEST);
	assign abort = expired;
	assign timeout_mark = expired;
	assign expect_id = cfg.id;
	assign req = '{kind: (state == ST_COMMAND) ? KIND_COMMAND : KIND_REQUEST,
		id: cfg.id, setpoint: cfg.setpoint};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_GAP;
			cnt <= '0;
			sel <= '0;
			issued <= 1'b0;
		end else begin
			case (state)
				ST_GAP: begin
					cnt <= cnt + 1'b1;
					if (cnt == CW'(`POLL_GAP_CYCLES - 1))
						state <= ST_REQUEST;
				end
				ST_REQUEST: begin
					if (send) begin
						state <= ST_AWAIT;
						cnt <= '0;
					end
				end
				ST_AWAIT: begin
					if (!sender_busy)
						cnt <= cnt + 1'b1; // timeout runs once the request is out
					if (rx_done) begin
						issued <= 1'b0;
						if (rx_result == RES_OK && rx_setpoint != cfg.setpoint)
							state <= ST_COMMAND;
						else
							state <= ST_NEXT;
					end else if (expired)
						state <= ST_NEXT;
				end
				ST_COMMAND: begin
					if (send)
						issued <= 1'b1;
					else if (issued && !sender_busy)
						state <= ST_NEXT;
				end
				ST_NEXT: begin
					sel <= (sel == motor_idx_t'(`NUM_MOTORS - 1)) ? '0 : sel + 1'b1;
					cnt <= '0;
					state <= ST_GAP;
				end
				default: state <= ST_GAP;
			endcase
		end
	end
endmodule

/* filelist.f */
+incdir+.
motor_bus_pkg.sv
uart_tx.sv
uart_rx.sv
frame_sender.sv
frame_receiver.sv
bus_poller.sv
motor_regs.sv
motor_bus_master.sv
bus_checker.sv
tb_motor_bus.sv

/* frame_receiver.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module frame_receiver (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [7:0]                   byte_data,
	input  logic                         byte_valid,
	input  logic                         arm,
	input  logic                         abort,
	input  logic [7:0]                   expect_id,
	output logic                         done,
	output motor_bus_pkg::poll_result_e  result,
	output motor_bus_pkg::motor_status_t status
);
	import motor_bus_pkg::*;

	typedef enum logic [1:0] {RX_IDLE, RX_HUNT, RX_COLLECT} rx_state_e;

	rx_state_e    state;
	logic [4:0]   cnt;
	logic [31:0]  window;
	logic [31:0]  next_window;
	logic [135:0] body; // id, then setpoint echo, position, velocity, duty
	logic [15:0]  crc;
	logic [7:0]   crc_hi;

	assign next_window = {window[23:0], byte_data};
	assign status = motor_status_t'(body[127:0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			cnt <= '0;
			done <= 1'b0;
			result <= RES_NEVER;
		end else begin
			done <= 1'b0;
			if (abort)
				state <= RX_IDLE;
			else if (arm)
				state <= RX_HUNT;
			else begin
				case (state)
					RX_HUNT: begin
						if (byte_valid && next_window == `RESP_HEADER) begin
							state <= RX_COLLECT;
							cnt <= 5'd4;
						end
					end
					RX_COLLECT: begin
						if (byte_valid) begin
							cnt <= cnt + 1'b1;
							if (cnt == 5'(`RESP_FRAME_LEN - 1)) begin
								state <= RX_IDLE;
								done <= 1'b1;
								if ({crc_hi, byte_data} != crc)
									result <= RES_BAD_CRC;
								else if (body[135:128] != expect_id)
									result <= RES_WRONG_ID;
								else
									result <= RES_OK;
							end
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arm)
			window <= '0; // forget bytes of the previous frame
		else if (state == RX_HUNT && byte_valid)
			window <= next_window;
		if (state == RX_HUNT) begin
			crc <= 16'hFFFF;
		end else if (state == RX_COLLECT && byte_valid) begin
			if (cnt < 5'(`RESP_FRAME_LEN - 2)) begin
				crc <= crc16_step(crc, byte_data);
				body <= {body[127:0], byte_data};
			end else if (cnt == 5'(`RESP_FRAME_LEN - 2))
				crc_hi <= byte_data;
		end
	end

	a_cnt_in_frame: assert property (@(posedge clk) disable iff (reset)
		state == RX_COLLECT |-> cnt < 5'(`RESP_FRAME_LEN));
endmodule

/* frame_sender.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module frame_sender (
	input  logic                     clk,
	input  logic                     reset,
	input  motor_bus_pkg::frame_req_t req,
	input  logic                     send,
	output logic                     busy,
	output logic [7:0]               byte_data,
	output logic                     byte_start,
	input  logic                     uart_busy
);
	import motor_bus_pkg::*;

	frame_req_t  cur;
	logic        sending;
	logic [3:0]  idx;
	logic [3:0]  len;
	logic [31:0] hdr;
	logic [1:0]  sp_sel;
	logic [15:0] crc;

	assign busy = sending || uart_busy;
	assign byte_start = sending && !uart_busy;
	assign hdr = (cur.kind == KIND_COMMAND) ? `CMD_HEADER : `REQ_HEADER;
	assign len = (cur.kind == KIND_COMMAND) ? 4'(`CMD_FRAME_LEN) : 4'(`REQ_FRAME_LEN);
	assign sp_sel = 2'(idx - 4'd5);

	always_comb begin
		if (idx < 4'd4)
			byte_data = hdr[31 - 8 * idx[1:0] -: 8];
		else if (idx == 4'd4)
			byte_data = cur.id;
		else if (idx == len - 4'd2)
			byte_data = crc[15:8];
		else if (idx == len - 4'd1)
			byte_data = crc[7:0];
		else
			byte_data = cur.setpoint[31 - 8 * sp_sel -: 8]; // command only
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sending <= 1'b0;
			idx <= '0;
		end else if (send && !sending) begin
			sending <= 1'b1;
			idx <= '0;
		end else if (byte_start) begin
			idx <= idx + 1'b1;
			if (idx == len - 4'd1)
				sending <= 1'b0;
		end
	end

	// crc over id and payload, header excluded
	always_ff @(posedge clk) begin
		if (send && !sending) begin
			cur <= req;
			crc <= 16'hFFFF;
		end else if (byte_start && idx >= 4'd4 && idx < len - 4'd2) begin
			crc <= crc16_step(crc, byte_data);
		end
	end
endmodule

/* motor_bus_master.sv */
`timescale 1ns/100ps

module motor_bus_master (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cyc,
	input  logic                                stb,
	input  logic                                we,
	input  logic [motor_bus_pkg::ADR_WIDTH-1:0] adr,
	input  logic [31:0]                         dat_w,
	output logic [31:0]                         dat_r,
	output logic                                ack,
	output logic                                tx_o,
	output logic                                tx_enable,
	input  logic                                rx_i
);
	import motor_bus_pkg::*;

	motor_idx_t    sel;
	motor_cfg_t    cfg;
	frame_req_t    req;
	motor_status_t rx_status;
	poll_result_e  rx_result;
	logic          send, sender_busy;
	logic          arm, abort, rx_done, timeout_mark;
	logic [7:0]    expect_id;
	logic [7:0]    tx_byte, rx_byte;
	logic          tx_start, tx_busy, rx_valid;

	motor_regs u_regs (.clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
		.sel, .cfg, .status(rx_status), .result(rx_result),
		.status_done(rx_done), .timeout_mark);

	bus_poller u_poller (.clk, .reset, .cfg, .sel, .req, .send, .sender_busy,
		.arm, .expect_id, .abort, .rx_done, .rx_result,
		.rx_setpoint(rx_status.setpoint), .timeout_mark);

	frame_sender u_sender (.clk, .reset, .req, .send, .busy(sender_busy),
		.byte_data(tx_byte), .byte_start(tx_start), .uart_busy(tx_busy));

	uart_tx u_tx (.clk, .reset, .byte_data(tx_byte), .byte_start(tx_start),
		.busy(tx_busy), .tx_o, .tx_enable);

	uart_rx u_rx (.clk, .reset, .rx_i, .byte_data(rx_byte), .byte_valid(rx_valid));

	frame_receiver u_recv (.clk, .reset, .byte_data(rx_byte), .byte_valid(rx_valid),
		.arm, .abort, .expect_id, .done(rx_done), .result(rx_result), .status(rx_status));
endmodule

/* motor_bus_params.svh */
`ifndef MOTOR_BUS_PARAMS_SVH
`define MOTOR_BUS_PARAMS_SVH

`define NUM_MOTORS          4
`define BIT_CYCLES          8
`define POLL_GAP_CYCLES     (16 * `BIT_CYCLES)
`define REQ_FRAME_LEN       7
`define CMD_FRAME_LEN       11
`define RESP_FRAME_LEN      23
`define RESP_TIMEOUT_CYCLES (`RESP_FRAME_LEN * 10 * `BIT_CYCLES + 40 * `BIT_CYCLES)

`define REQ_HEADER  32'h1CE1CEBB
`define CMD_HEADER  32'hCAFEBABE
`define RESP_HEADER 32'hDABAD000

`endif

/* motor_bus_pkg.sv */
`include "motor_bus_params.svh"

package motor_bus_pkg;
	typedef logic [$clog2(`NUM_MOTORS)-1:0] motor_idx_t;

	// host address is {motor index, register select}
	localparam int ADR_WIDTH = $bits(motor_idx_t) + 3;

	typedef enum logic [1:0] {KIND_REQUEST, KIND_COMMAND} frame_kind_e;

	typedef enum logic [2:0] {
		RES_NEVER, RES_OK, RES_TIMEOUT, RES_BAD_CRC, RES_WRONG_ID
	} poll_result_e;

	typedef enum logic [2:0] {
		REG_SETPOINT, REG_ID, REG_ECHO, REG_POSITION, REG_VELOCITY, REG_DUTY, REG_RESULT
	} reg_sel_e;

	typedef struct packed {
		logic [7:0]         id;
		logic signed [31:0] setpoint;
	} motor_cfg_t;

	typedef struct packed {
		logic signed [31:0] setpoint;
		logic signed [31:0] position;
		logic signed [31:0] velocity;
		logic signed [31:0] duty;
	} motor_status_t;

	typedef struct packed {
		frame_kind_e        kind;
		logic [7:0]         id;
		logic signed [31:0] setpoint;
	} frame_req_t;

	// ccitt poly 0x1021, msb first
	function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc ^ {data, 8'h00};
		for (int i = 0; i < 8; i++)
			c = c[15] ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		return c;
	endfunction
endpackage

/* motor_regs.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module motor_regs (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cyc,
	input  logic                                stb,
	input  logic                                we,
	input  logic [motor_bus_pkg::ADR_WIDTH-1:0] adr,
	input  logic [31:0]                         dat_w,
	output logic [31:0]                         dat_r,
	output logic                                ack,
	input  motor_bus_pkg::motor_idx_t           sel,
	output motor_bus_pkg::motor_cfg_t           cfg,
	input  motor_bus_pkg::motor_status_t        status,
	input  motor_bus_pkg::poll_result_e         result,
	input  logic                                status_done,
	input  logic                                timeout_mark
);
	import motor_bus_pkg::*;

	motor_cfg_t    cfg_mem    [`NUM_MOTORS];
	motor_status_t status_mem [`NUM_MOTORS];
	poll_result_e  result_mem [`NUM_MOTORS];
	motor_idx_t    midx;
	reg_sel_e      rsel;
	logic          access;

	assign midx = adr[ADR_WIDTH-1:3];
	assign rsel = reg_sel_e'(adr[2:0]);
	assign access = cyc && stb && !ack; // one ack per request
	assign cfg = cfg_mem[sel];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack <= 1'b0;
			for (int i = 0; i < `NUM_MOTORS; i++) begin
				cfg_mem[i] <= '0;
				result_mem[i] <= RES_NEVER;
			end
		end else begin
			ack <= access;
			if (access && we) begin
				case (rsel)
					REG_SETPOINT: cfg_mem[midx].setpoint <= dat_w;
					REG_ID:       cfg_mem[midx].id <= dat_w[7:0];
					default: ;
				endcase
			end
			if (status_done)
				result_mem[sel] <= result;
			else if (timeout_mark)
				result_mem[sel] <= RES_TIMEOUT;
		end
	end

	always_ff @(posedge clk) begin
		if (status_done && result == RES_OK)
			status_mem[sel] <= status; // failed polls keep the old status
		if (access && !we) begin
			case (rsel)
				REG_SETPOINT: dat_r <= cfg_mem[midx].setpoint;
				REG_ID:       dat_r <= {24'h0, cfg_mem[midx].id};
				REG_ECHO:     dat_r <= status_mem[midx].setpoint;
				REG_POSITION: dat_r <= status_mem[midx].position;
				REG_VELOCITY: dat_r <= status_mem[midx].velocity;
				REG_DUTY:     dat_r <= status_mem[midx].duty;
				REG_RESULT:   dat_r <= 32'(result_mem[midx]);
				default:      dat_r <= '0;
			endcase
		end
	end

	a_ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
		ack |-> cyc && stb);
endmodule

/* tb_motor_bus.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module tb_motor_bus;
	import motor_bus_pkg::*;

	localparam int BIT = `BIT_CYCLES;
	localparam int NUM_TESTS = 24;
	// request, timeout, command and gap
	localparam int EXCHANGE_MAX = 18 * 10 * BIT + `RESP_TIMEOUT_CYCLES + `POLL_GAP_CYCLES;
	localparam int CYCLE_LIMIT = (NUM_TESTS + 1) * EXCHANGE_MAX * 2;
	localparam logic [31:0] RESP_HDR = `RESP_HEADER;

	logic                 clk, reset;
	logic                 cyc, stb, we, ack;
	logic [ADR_WIDTH-1:0] adr;
	logic [31:0]          dat_w, dat_r;
	logic                 tx_o, tx_enable, rx_i;
	logic                 exp_valid;
	motor_idx_t           exp_idx;
	logic [1:0]           exp_kind; // 0 ok, 1 bad crc, 2 foreign id, 3 silent
	motor_status_t        exp_status;
	int                   checks, errors;
	int                   cycles = 0;
	integer               seed;
	logic [7:0]           frame_q [$];
	logic [7:0]           ids [`NUM_MOTORS];
	logic signed [31:0]   sps [`NUM_MOTORS];
	logic                 has_status [`NUM_MOTORS];
	logic                 cmd_due;

	motor_bus_master u_dut (.clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
		.tx_o, .tx_enable, .rx_i);

	bus_checker u_checker (.clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
		.tx_o, .tx_enable, .exp_valid, .exp_idx, .exp_kind, .exp_status, .checks, .errors);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] crc_add(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		c = crc;
		for (int i = 7; i >= 0; i--)
			c = (c[15] ^ b[i]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		return c;
	endfunction

	task automatic wb_cycle(input logic write, input motor_idx_t m, input logic [2:0] rs,
		input logic [31:0] d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= {m, rs};
		dat_w <= d;
		do @(posedge clk); while (!ack);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic read_regs(input motor_idx_t m);
		for (int r = 0; r < 7; r++)
			if (r < 2 || r == 6 || has_status[m])
				wb_cycle(1'b0, m, 3'(r), 32'h0);
	endtask

	task automatic set_config(input motor_idx_t m);
		ids[m] = 8'($random(seed));
		sps[m] = $random(seed);
		wb_cycle(1'b1, m, 3'd0, sps[m]);
		wb_cycle(1'b1, m, 3'd1, {24'($random(seed)), ids[m]}); // upper bits ignored
		wb_cycle(1'b0, m, 3'd0, 32'h0);
		wb_cycle(1'b0, m, 3'd1, 32'h0);
	endtask

	// motor side uart decoder, one frame up to tx_enable falling
	task automatic get_frame;
		logic [7:0] b;
		frame_q.delete();
		while (!tx_enable) @(posedge clk);
		while (tx_enable) begin
			@(posedge clk);
			if (tx_enable && !tx_o) begin
				repeat (BIT / 2) @(posedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT) @(posedge clk);
					b[i] = tx_o;
				end
				repeat (BIT) @(posedge clk);
				frame_q.push_back(b);
			end
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx_i <= bits[i];
			repeat (BIT) @(posedge clk);
		end
	endtask

	task automatic respond(input motor_idx_t m);
		logic [1:0]    kind;
		motor_status_t st;
		logic [7:0]    body [$];
		logic [15:0]   crc;
		kind = 2'($random(seed));
		if ($random(seed) & 1)
			st.setpoint = sps[m];
		else
			st.setpoint = sps[m] + 32'sd7; // stale echo
		st.position = $random(seed);
		st.velocity = $random(seed);
		st.duty = $random(seed);
		@(posedge clk);
		exp_valid <= 1'b1;
		exp_idx <= m;
		exp_kind <= kind;
		exp_status <= st;
		@(posedge clk);
		exp_valid <= 1'b0;
		cmd_due = (kind == 2'd0) && (st.setpoint != sps[m]);
		if (kind == 2'd0)
			has_status[m] = 1'b1;
		if (kind != 2'd3) begin
			// id as addressed by the request
			body.push_back((kind == 2'd2) ? frame_q[4] + 8'd1 : frame_q[4]);
			for (int f = 0; f < 16; f++)
				body.push_back(st[127 - 8 * f -: 8]);
			crc = 16'hFFFF;
			foreach (body[i])
				crc = crc_add(crc, body[i]);
			if (kind == 2'd1)
				crc = crc ^ 16'h0100;
			for (int i = 0; i < 4; i++)
				send_byte(RESP_HDR[31 - 8 * i -: 8]);
			foreach (body[i])
				send_byte(body[i]);
			send_byte(crc[15:8]);
			send_byte(crc[7:0]);
		end
	endtask

	initial begin
		seed = 56707;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		rx_i = 1'b1;
		exp_valid = 1'b0;
		exp_idx = '0;
		exp_kind = '0;
		exp_status = '0;
		cmd_due = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			has_status[m] = 1'b0;
			wb_cycle(1'b0, motor_idx_t'(m), 3'd6, 32'h0); // never polled
		end
		for (int m = 0; m < `NUM_MOTORS; m++)
			set_config(motor_idx_t'(m));
		for (int t = 0; t < NUM_TESTS; t++) begin
			get_frame();
			// previous exchange is over once a new request went out
			if (t > 0) begin
				read_regs(motor_idx_t'((t - 1) % `NUM_MOTORS));
				if ($random(seed) & 1)
					set_config(motor_idx_t'((t - 1) % `NUM_MOTORS));
			end
			respond(motor_idx_t'(t % `NUM_MOTORS));
			if (cmd_due)
				get_frame();
		end
		get_frame();
		read_regs(motor_idx_t'((NUM_TESTS - 1) % `NUM_MOTORS));
		repeat (2) @(posedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

/* uart_rx.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module uart_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_i,
	output logic [7:0] byte_data,
	output logic       byte_valid
);
	localparam int TW = $clog2(`BIT_CYCLES + 1);

	logic [1:0]    sync;
	logic          rx_s;
	logic          rx_prev;
	logic          active;
	logic [TW-1:0] tick;
	logic [3:0]    bit_idx;
	logic [7:0]    shreg;
	logic          mid;
	logic          last_tick;

	assign rx_s = sync[1];
	assign mid = (tick == TW'(`BIT_CYCLES / 2));
	assign last_tick = (tick == TW'(`BIT_CYCLES - 1));
	assign byte_data = shreg;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync <= 2'b11;
			rx_prev <= 1'b1;
			active <= 1'b0;
			tick <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			sync <= {sync[0], rx_i};
			rx_prev <= rx_s;
			byte_valid <= 1'b0;
			if (!active) begin
				if (rx_prev && !rx_s) begin // falling edge of start bit
					active <= 1'b1;
					tick <= TW'(1);
					bit_idx <= '0;
				end
			end else begin
				tick <= last_tick ? '0 : tick + 1'b1;
				if (last_tick)
					bit_idx <= bit_idx + 1'b1;
				if (mid && bit_idx == 4'd0 && rx_s)
					active <= 1'b0; // glitch, not a start bit
				else if (mid && bit_idx == 4'd9) begin
					active <= 1'b0;
					byte_valid <= rx_s; // bad stop bit drops the byte
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active && mid && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shreg <= {rx_s, shreg[7:1]}; // lsb first
	end
endmodule

/* uart_tx.sv */
`timescale 1ns/100ps
`include "motor_bus_params.svh"

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] byte_data,
	input  logic       byte_start,
	output logic       busy,
	output logic       tx_o,
	output logic       tx_enable
);
	localparam int TW = $clog2(`BIT_CYCLES + 1);

	logic [9:0]    shreg;
	logic [TW-1:0] tick;
	logic [3:0]    bit_idx; // 0 start, 1..8 data, 9 stop, 10 idle bit
	logic          active;
	logic          last_tick;

	assign last_tick = (tick == TW'(`BIT_CYCLES - 1));
	// free already in the last stop cycle so the next byte follows without a gap
	assign busy = active && (bit_idx < 4'd9 || (bit_idx == 4'd9 && !last_tick));
	assign tx_o = active ? shreg[0] : 1'b1;
	assign tx_enable = active;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			tick <= '0;
			bit_idx <= '0;
		end else if (byte_start) begin
			active <= 1'b1;
			tick <= '0;
			bit_idx <= '0;
		end else if (active) begin
			tick <= last_tick ? '0 : tick + 1'b1;
			if (last_tick) begin
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd10)
					active <= 1'b0; // transceiver released after idle bit
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_start)
			shreg <= {1'b1, byte_data, 1'b0};
		else if (active && last_tick)
			shreg <= {1'b1, shreg[9:1]};
	end

	a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
		byte_start |-> !busy);
endmodule
